// File: corePkg.sv
package corePkg;

	// ==============================
	// response word fields
	// ==============================

	// one returned operand
	localparam int dataWidth = 64;

	// transaction tag, echoed from the request
	localparam int tagWidth = 8;

	// operand size code
	localparam int sizeWidth = 3;

	// ==============================
	// response buffers
	// ==============================

	// entries per buffer, also the credits a sender starts with
	localparam int fifoDepth = 16;

	// read and write pointer width
	localparam int ptrWidth = $clog2(fifoDepth);

	// occupancy must reach fifoDepth itself, hence one extra bit
	localparam int creditWidth = $clog2(fifoDepth + 1);

endpackage

// File: respIf.sv
`timescale 1ns/1ps

interface respIf;
	import corePkg::*;

	// response present at the source
	logic valid;

	// response fields, stable while valid waits for pop
	logic [sizeWidth-1:0] size;
	logic [tagWidth-1:0] tag;
	logic [dataWidth-1:0] data;

	// sink takes the response at the next edge
	logic pop;

	modport source
	(
		output valid, size, tag, data,
		input pop
	);

	modport sink
	(
		input valid, size, tag, data,
		output pop
	);

endinterface

// File: respFifo.sv
`timescale 1ns/1ps

module respFifo
(
	input logic EXTCLK,
	input logic rst,
	input logic wrValid,
	input logic [corePkg::sizeWidth-1:0] wrSize,
	input logic [corePkg::tagWidth-1:0] wrTag,
	input logic [corePkg::dataWidth-1:0] wrData,
	output logic credit,
	respIf.source out
);
	import corePkg::*;

	// entry storage
	logic [sizeWidth-1:0] sizeMem [fifoDepth];
	logic [tagWidth-1:0] tagMem [fifoDepth];
	logic [dataWidth-1:0] dataMem [fifoDepth];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [creditWidth-1:0] entryCount;

	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (entryCount == '0);
	assign full = (entryCount == creditWidth'(fifoDepth));

	// a write into a full buffer is dropped; the sender broke the credit rule
	assign push = wrValid && !full;
	assign pop = out.pop && !empty;

	// ==============================
	// head entry toward the mux
	// ==============================
	assign out.valid = !empty;
	assign out.size = sizeMem[rdPtr];
	assign out.tag = tagMem[rdPtr];
	assign out.data = dataMem[rdPtr];

	// one credit back per entry leaving
	assign credit = pop;

	always_ff @(posedge EXTCLK)
	begin
		if (push)
		begin
			sizeMem[wrPtr] <= wrSize;
			tagMem[wrPtr] <= wrTag;
			dataMem[wrPtr] <= wrData;
		end
	end

	// pointers and occupancy
	always_ff @(posedge EXTCLK)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			entryCount <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + ptrWidth'(1);
			if (pop)
				rdPtr <= rdPtr + ptrWidth'(1);
			case ({push, pop})
				2'b10: entryCount <= entryCount + creditWidth'(1);
				2'b01: entryCount <= entryCount - creditWidth'(1);
				default: entryCount <= entryCount;
			endcase
		end
	end

	// ==============================
	// protocol checks
	// ==============================

	// sender wrote without holding a credit
	writeWithoutCredit: assert property (@(posedge EXTCLK) disable iff (rst)
		wrValid |-> !full)
		else $error("respFifo: write while full");

	// mux must not pop an empty buffer
	popWhenEmpty: assert property (@(posedge EXTCLK) disable iff (rst)
		out.pop |-> !empty)
		else $error("respFifo: pop while empty");

	// occupancy stays within the entries
	occupancyBound: assert property (@(posedge EXTCLK) disable iff (rst)
		entryCount <= creditWidth'(fifoDepth))
		else $error("respFifo: occupancy above depth");

endmodule

// File: dataPathMux.sv
`timescale 1ns/1ps

module dataPathMux
(
	input logic EXTCLK,
	input logic rst,
	respIf.sink netIn,
	respIf.sink streamIn,
	respIf.sink localIn,
	output logic drdy,
	output logic [corePkg::tagWidth-1:0] tag,
	output logic [corePkg::sizeWidth-1:0] size,
	output logic [corePkg::dataWidth-1:0] data
);
	import corePkg::*;

	logic netGrant;
	logic streamGrant;
	logic localGrant;
	logic anyValid;

	logic [tagWidth-1:0] selTag;
	logic [sizeWidth-1:0] selSize;
	logic [dataWidth-1:0] selData;

	// ==============================
	// fixed priority grant
	// ==============================

	// network first, then stream, local last
	assign netGrant = netIn.valid;
	assign streamGrant = streamIn.valid && !netIn.valid;
	assign localGrant = localIn.valid && !netIn.valid && !streamIn.valid;
	assign anyValid = netIn.valid || streamIn.valid || localIn.valid;

	// the granted source drops its entry at the next edge
	assign netIn.pop = netGrant;
	assign streamIn.pop = streamGrant;
	assign localIn.pop = localGrant;

	// entry selection
	always_comb
	begin
		if (netGrant)
		begin
			selTag = netIn.tag;
			selSize = netIn.size;
			selData = netIn.data;
		end
		else if (streamGrant)
		begin
			selTag = streamIn.tag;
			selSize = streamIn.size;
			selData = streamIn.data;
		end
		else
		begin
			selTag = localIn.tag;
			selSize = localIn.size;
			selData = localIn.data;
		end
	end

	// ==============================
	// output register
	// ==============================

	// one response per cycle, execution unit never stalls
	always_ff @(posedge EXTCLK)
	begin
		if (rst)
		begin
			drdy <= 1'b0;
			tag <= '0;
			size <= '0;
			data <= '0;
		end
		else
		begin
			drdy <= anyValid;
			if (anyValid)
			begin
				tag <= selTag;
				size <= selSize;
				data <= selData;
			end
		end
	end

	// only one source leaves per cycle
	singlePop: assert property (@(posedge EXTCLK) disable iff (rst)
		$onehot0({netIn.pop, streamIn.pop, localIn.pop}))
		else $error("dataPathMux: more than one pop");

	// a waiting higher source blocks the lower ones
	priorityOrder: assert property (@(posedge EXTCLK) disable iff (rst)
		(streamIn.pop |-> !netIn.valid) and
		(localIn.pop |-> !(netIn.valid || streamIn.valid)))
		else $error("dataPathMux: lower source popped over a valid higher one");

endmodule

// File: coreReturnPath.sv
`timescale 1ns/1ps

module coreReturnPath
(
	input logic EXTCLK,
	input logic rst,

	// stream controller responses
	input logic streamValid,
	input logic [corePkg::sizeWidth-1:0] streamSize,
	input logic [corePkg::tagWidth-1:0] streamTag,
	input logic [corePkg::dataWidth-1:0] streamData,
	output logic streamCredit,

	// network controller responses
	input logic netValid,
	input logic [corePkg::sizeWidth-1:0] netSize,
	input logic [corePkg::tagWidth-1:0] netTag,
	input logic [corePkg::dataWidth-1:0] netData,
	output logic netCredit,

	// local memory channel, held until read
	input logic localValid,
	input logic [corePkg::sizeWidth-1:0] localSize,
	input logic [corePkg::tagWidth-1:0] localTag,
	input logic [corePkg::dataWidth-1:0] localData,
	output logic localRead,

	// toward the execution unit
	output logic drdy,
	output logic [corePkg::tagWidth-1:0] tag,
	output logic [corePkg::sizeWidth-1:0] size,
	output logic [corePkg::dataWidth-1:0] data
);

	respIf netResp();
	respIf streamResp();
	respIf localResp();

	// ==============================
	// buffered sources
	// ==============================
	respFifo streamFifo
	(
		.EXTCLK(EXTCLK),
		.rst(rst),
		.wrValid(streamValid),
		.wrSize(streamSize),
		.wrTag(streamTag),
		.wrData(streamData),
		.credit(streamCredit),
		.out(streamResp.source)
	);

	respFifo netFifo
	(
		.EXTCLK(EXTCLK),
		.rst(rst),
		.wrValid(netValid),
		.wrSize(netSize),
		.wrTag(netTag),
		.wrData(netData),
		.credit(netCredit),
		.out(netResp.source)
	);

	// local channel goes straight to the mux
	assign localResp.valid = localValid;
	assign localResp.size = localSize;
	assign localResp.tag = localTag;
	assign localResp.data = localData;
	assign localRead = localResp.pop;

	dataPathMux coreMux
	(
		.EXTCLK(EXTCLK),
		.rst(rst),
		.netIn(netResp.sink),
		.streamIn(streamResp.sink),
		.localIn(localResp.sink),
		.drdy(drdy),
		.tag(tag),
		.size(size),
		.data(data)
	);

endmodule

// File: tbCoreReturnPath.sv
`timescale 1ns/1ps

module tbCoreReturnPath;
	import corePkg::*;

	localparam int entryWidth = sizeWidth + tagWidth + dataWidth;
	localparam int cycleLimit = 4000;
	localparam int localSrc = 0;
	localparam int streamSrc = 1;
	localparam int netSrc = 2;

	logic EXTCLK = 1'b0;
	logic rst;
	logic streamValid, netValid, localValid;
	logic [sizeWidth-1:0] streamSize, netSize, localSize;
	logic [tagWidth-1:0] streamTag, netTag, localTag;
	logic [dataWidth-1:0] streamData, netData, localData;
	logic streamCredit, netCredit, localRead, drdy;
	logic [tagWidth-1:0] tag;
	logic [sizeWidth-1:0] size;
	logic [dataWidth-1:0] data;

	// expected entries per source, packed as {size, tag, data}
	logic [entryWidth-1:0] netQ[$], streamQ[$], localQ[$];
	// edge at which each buffered entry was captured
	int netEdge[$], streamEdge[$];
	int netIdx = 0, streamIdx = 0, localIdx = 0;
	int netWrites = 0, streamWrites = 0, localIssued = 0;
	int netReturned = 0, streamReturned = 0, localReads = 0;
	logic [tagWidth-3:0] netSeq = '0, streamSeq = '0, localSeq = '0;
	int seed;
	int cycleCount = 0;
	int pendingSrc = -1;
	bit started = 1'b0;
	int valueErrors = 0, protocolErrors = 0, endErrors = 0, timeoutErrors = 0;

	coreReturnPath coreReturnPath_inst (.*);

	always #20 EXTCLK = ~EXTCLK;

	function automatic bit chance(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	// tag holds the source number on top and the sequence count below
	function automatic logic [entryWidth-1:0] makeEntry(input int src,
		input logic [tagWidth-3:0] seq);
		logic [sizeWidth-1:0] sz;
		logic [dataWidth-1:0] dt;
		sz = sizeWidth'($random(seed));
		dt = {$random(seed), $random(seed)};
		return {sz, 2'(src), seq, dt};
	endfunction

	// oldest response of a source not yet seen on drdy
	function automatic logic [entryWidth-1:0] expectedEntry(input int src);
		case (src)
			netSrc: return netQ[netIdx];
			streamSrc: return streamQ[streamIdx];
			default: return localQ[localIdx];
		endcase
	endfunction

	function automatic int outstanding(input int src);
		case (src)
			netSrc: return netQ.size() - netIdx;
			streamSrc: return streamQ.size() - streamIdx;
			default: return localQ.size() - localIdx;
		endcase
	endfunction

	// oldest pending entry was already valid in the pop cycle of the shown response
	function automatic bit heldBack(input int src);
		if (src == netSrc)
			return netIdx < netQ.size() && netEdge[netIdx] <= cycleCount - 2;
		return streamIdx < streamQ.size() && streamEdge[streamIdx] <= cycleCount - 2;
	endfunction

	function automatic bit allConsumed();
		return outstanding(netSrc) == 0 && outstanding(streamSrc) == 0 &&
			outstanding(localSrc) == 0;
	endfunction

	task automatic printCounts();
		$display("errors: value %0d, protocol %0d, end of test %0d, timeout %0d",
			valueErrors, protocolErrors, endErrors, timeoutErrors);
	endtask

	// one falling edge of stimulus with writes only while a credit is held
	task automatic driveCycle(input int netPct, input int streamPct, input int localPct);
		logic [entryWidth-1:0] entry;
		netValid = 1'b0;
		streamValid = 1'b0;
		if (netWrites - netReturned < fifoDepth && chance(netPct))
		begin
			entry = makeEntry(netSrc, netSeq);
			{netSize, netTag, netData} = entry;
			netQ.push_back(entry);
			netEdge.push_back(cycleCount + 1);
			netSeq++;
			netWrites++;
			netValid = 1'b1;
		end
		if (streamWrites - streamReturned < fifoDepth && chance(streamPct))
		begin
			entry = makeEntry(streamSrc, streamSeq);
			{streamSize, streamTag, streamData} = entry;
			streamQ.push_back(entry);
			streamEdge.push_back(cycleCount + 1);
			streamSeq++;
			streamWrites++;
			streamValid = 1'b1;
		end
		// local response stays up until it has been read
		if (localReads == localIssued)
		begin
			localValid = 1'b0;
			if (chance(localPct))
			begin
				entry = makeEntry(localSrc, localSeq);
				{localSize, localTag, localData} = entry;
				localQ.push_back(entry);
				localSeq++;
				localIssued++;
				localValid = 1'b1;
			end
		end
	endtask

	// ==============================
	// response monitor
	// ==============================
	always @(posedge EXTCLK)
	begin
		int src;
		logic [entryWidth-1:0] exp;
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			timeoutErrors = 1;
			$display("timeout: test did not finish within %0d cycles", cycleLimit);
			printCounts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
		else if (rst)
			pendingSrc = -1;
		else
		begin
			if (!started)
			begin
				assert (!drdy && !streamCredit && !netCredit && !localRead)
				else
				begin
					protocolErrors++;
					$display("output active at %0t before any input was given", $time);
				end
				// output register still holds its reset value
				assert (tag == '0)
				else
				begin
					valueErrors++;
					$display("FAILED time %0t tag got %h expected 0", $time, tag);
				end
				assert (size == '0)
				else
				begin
					valueErrors++;
					$display("FAILED time %0t size got %h expected 0", $time, size);
				end
				assert (data == '0)
				else
				begin
					valueErrors++;
					$display("FAILED time %0t data got %h expected 0", $time, data);
				end
			end
			assert (!localRead || localValid)
			else
			begin
				protocolErrors++;
				$display("localRead pulsed at %0t while localValid was low", $time);
			end
			// drdy follows a pop by exactly one cycle
			assert (drdy == (pendingSrc >= 0))
			else
			begin
				protocolErrors++;
				$display("drdy was %b at %0t, source popped one cycle earlier: %0d",
					drdy, $time, pendingSrc);
			end
			if (drdy)
			begin
				src = int'(tag[tagWidth-1 -: 2]);
				if (src > netSrc || outstanding(src) == 0)
				begin
					protocolErrors++;
					$display("response with tag %h at %0t matches nothing outstanding",
						tag, $time);
				end
				else
				begin
					exp = expectedEntry(src);
					assert (tag == exp[dataWidth +: tagWidth])
					else
					begin
						valueErrors++;
						$display("FAILED time %0t tag got %h expected %h",
							$time, tag, exp[dataWidth +: tagWidth]);
					end
					assert (size == exp[entryWidth-1 -: sizeWidth])
					else
					begin
						valueErrors++;
						$display("FAILED time %0t size got %h expected %h",
							$time, size, exp[entryWidth-1 -: sizeWidth]);
					end
					assert (data == exp[dataWidth-1:0])
					else
					begin
						valueErrors++;
						$display("FAILED time %0t data got %h expected %h",
							$time, data, exp[dataWidth-1:0]);
					end
					assert (src == pendingSrc)
					else
					begin
						protocolErrors++;
						$display("source %0d returned at %0t but source %0d was popped",
							src, $time, pendingSrc);
					end
					// a waiting higher source must have won the pop
					if (src != netSrc)
					begin
						assert (!heldBack(netSrc))
						else
						begin
							protocolErrors++;
							$display("lower source returned at %0t over a waiting network entry",
								$time);
						end
					end
					if (src == localSrc)
					begin
						assert (!heldBack(streamSrc))
						else
						begin
							protocolErrors++;
							$display("local returned at %0t over a waiting stream entry", $time);
						end
					end
					if (src == netSrc)
						netIdx++;
					else if (src == streamSrc)
						streamIdx++;
					else
						localIdx++;
				end
			end
			assert ($onehot0({netCredit, streamCredit, localRead}))
			else
			begin
				protocolErrors++;
				$display("more than one source popped at %0t", $time);
			end
			pendingSrc = netCredit ? netSrc : streamCredit ? streamSrc : localRead ? localSrc : -1;
			if (netCredit)
				netReturned++;
			if (streamCredit)
				streamReturned++;
			if (localRead)
				localReads++;
			assert (netReturned <= netWrites && streamReturned <= streamWrites &&
				localReads <= localIssued)
			else
			begin
				protocolErrors++;
				$display("credit or read at %0t with nothing written", $time);
			end
		end
	end

	// ==============================
	// stimulus
	// ==============================
	initial
	begin
		seed = 88;
		rst = 1'b1;
		{streamValid, netValid, localValid} = '0;
		{streamSize, netSize, localSize} = '0;
		{streamTag, netTag, localTag} = '0;
		{streamData, netData, localData} = '0;
		repeat (10) @(posedge EXTCLK);
		@(negedge EXTCLK);
		rst = 1'b0;
		// quiet outputs after reset
		repeat (5) @(negedge EXTCLK);
		started = 1'b1;
		// mixed traffic from all three sources
		repeat (500)
		begin
			@(negedge EXTCLK);
			driveCycle(25, 50, 50);
		end
		// network burst while stream and local keep the lower priorities busy
		repeat (fifoDepth)
		begin
			@(negedge EXTCLK);
			driveCycle(100, 100, 100);
		end
		// stream alone starves local
		repeat (60)
		begin
			@(negedge EXTCLK);
			driveCycle(0, 100, 100);
		end
		while (!allConsumed())
		begin
			@(negedge EXTCLK);
			driveCycle(0, 0, 0);
		end
		repeat (4)
		begin
			@(negedge EXTCLK);
			driveCycle(0, 0, 0);
		end
		// all credits home and one read per local response
		assert (netWrites == netReturned)
		else
		begin
			endErrors++;
			$display("network credits end at %0d instead of %0d",
				fifoDepth - netWrites + netReturned, fifoDepth);
		end
		assert (streamWrites == streamReturned)
		else
		begin
			endErrors++;
			$display("stream credits end at %0d instead of %0d",
				fifoDepth - streamWrites + streamReturned, fifoDepth);
		end
		assert (localReads == localIssued)
		else
		begin
			endErrors++;
			$display("%0d local reads for %0d local responses", localReads, localIssued);
		end
		printCounts();
		if (valueErrors + protocolErrors + endErrors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sources.f
corePkg.sv
respIf.sv
respFifo.sv
dataPathMux.sv
coreReturnPath.sv
tbCoreReturnPath.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tbCoreReturnPath \
	-f sources.f -o simCoreReturnPath \
	&& ./obj_dir/simCoreReturnPath | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
